// File: design/bp_pkg.sv
// Branch predictor shared types

package bp_pkg;

	// ========================================
	// Address and index widths
	// ========================================

	// Instruction address
	typedef logic [31:0] pc_t;

	// Counter table index
	// Address bits 7:2 joined with history bits 2:1
	typedef logic [7:0] bht_idx_t;

	// Two-bit prediction counter
	// 0 and 1 predict taken, 2 and 3 predict not taken
	typedef logic [1:0] ctr_t;

	// Global branch history, newest outcome in bit 0
	typedef logic [2:0] ghist_t;

	// Target cache index, address bits 7:2
	typedef logic [5:0] btc_idx_t;

	// ========================================
	// Resolve port FSM
	// ========================================

	// RP_IDLE   waiting for upd_req
	// RP_WRITE  update captured, tables written at the next edge
	// RP_ACK    upd_ack high until upd_req drops
	typedef enum logic [1:0] {
		RP_IDLE  = 2'd0,
		RP_WRITE = 2'd1,
		RP_ACK   = 2'd2
	} rp_state_t;

endpackage

// File: design/resolve_port.sv
// Resolved branch handshake receiver

`timescale 1ns/10ps

module resolve_port (
	input  logic        clk,
	input  logic        rst,
	input  logic        upd_req,
	input  bp_pkg::pc_t upd_pc,
	input  logic        upd_taken,
	input  bp_pkg::pc_t upd_target,
	output logic        upd_ack,
	output logic        wr_valid,
	output bp_pkg::pc_t wr_pc,
	output logic        wr_taken,
	output bp_pkg::pc_t wr_target
);

	import bp_pkg::*;

	rp_state_t state;
	logic      capture;

	// Request seen while idle
	assign capture = (state == RP_IDLE) && upd_req;

	// ========================================
	// Handshake FSM
	// ========================================

	// Idle, capture, one write cycle, then hold ack until req drops
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= RP_IDLE;
			wr_valid <= 1'b0;
			upd_ack  <= 1'b0;
		end else begin
			unique case (state)
				RP_IDLE: begin
					if (upd_req) begin
						state    <= RP_WRITE;
						wr_valid <= 1'b1;
					end
				end
				RP_WRITE: begin
					// Tables take the update on this edge
					state    <= RP_ACK;
					wr_valid <= 1'b0;
					upd_ack  <= 1'b1;
				end
				RP_ACK: begin
					// Sender has seen ack and released the request
					if (!upd_req) begin
						state   <= RP_IDLE;
						upd_ack <= 1'b0;
					end
				end
				default: begin
					state    <= RP_IDLE;
					wr_valid <= 1'b0;
					upd_ack  <= 1'b0;
				end
			endcase
		end
	end

	// Update fields held stable through the write cycle
	always_ff @(posedge clk) begin
		if (capture) begin
			wr_pc     <= upd_pc;
			wr_taken  <= upd_taken;
			wr_target <= upd_target;
		end
	end

	// One table write per update
	a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
		wr_valid |=> !wr_valid);

	// Ack must be gone before a new request is taken
	a_ack_idle: assert property (@(posedge clk) disable iff (rst)
		(state == RP_IDLE) |-> !upd_ack);

endmodule

// File: design/branch_history.sv
// Global history counter table

`timescale 1ns/10ps

module branch_history (
	input  logic        clk,
	input  logic        rst,
	input  bp_pkg::pc_t fetch_pc,
	input  logic        wr_valid,
	input  bp_pkg::pc_t wr_pc,
	input  logic        wr_taken,
	output logic        pred_taken
);

	import bp_pkg::*;

	// Global history, newest outcome in bit 0
	ghist_t   ghist;

	// 256 two-bit counters
	ctr_t     ctr_table [256];

	bht_idx_t rd_idx;
	bht_idx_t wr_idx;
	ctr_t     rd_ctr;
	ctr_t     wr_ctr;
	ctr_t     wr_ctr_next;

	// Counters power up at 0, weakly taken
	initial begin
		for (int i = 0; i < 256; i++) begin
			ctr_table[i] = 2'd0;
		end
	end

	// ========================================
	// Prediction side
	// ========================================

	// Fetch address plus the two older history bits
	assign rd_idx = {fetch_pc[7:2], ghist[2:1]};
	assign rd_ctr = ctr_table[rd_idx];

	// 0 and 1 mean taken
	assign pred_taken = (rd_ctr == 2'd0) || (rd_ctr == 2'd1);

	// ========================================
	// Update side
	// ========================================

	// Same index form, built from the resolved branch address
	assign wr_idx = {wr_pc[7:2], ghist[2:1]};
	assign wr_ctr = ctr_table[wr_idx];

	// Taken walks 2,3,0,1 and sticks at 1
	// Not taken walks 1,0,3,2 and sticks at 2
	always_comb begin
		if (wr_taken) begin
			wr_ctr_next = (wr_ctr == 2'd1) ? wr_ctr : wr_ctr + 2'd1;
		end else begin
			wr_ctr_next = (wr_ctr == 2'd2) ? wr_ctr : wr_ctr - 2'd1;
		end
	end

	// Counter update for each resolved branch
	always @(posedge clk) begin
		if (wr_valid) begin
			ctr_table[wr_idx] <= wr_ctr_next;
		end
	end

	// History shifts left once per resolved branch
	always_ff @(posedge clk) begin
		if (rst) begin
			ghist <= '0;
		end else if (wr_valid) begin
			ghist <= {ghist[1:0], wr_taken};
		end
	end

	// Prediction must be known once out of reset
	a_pred_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(pred_taken));

endmodule

// File: design/target_predictor.sv
// Branch target cache and next fetch address

`timescale 1ns/10ps

module target_predictor #(
	parameter int BTC_TAG_W = 24
) (
	input  logic        clk,
	input  logic        rst,
	input  bp_pkg::pc_t fetch_pc,
	input  logic        pred_taken,
	input  logic        wr_valid,
	input  bp_pkg::pc_t wr_pc,
	input  logic        wr_taken,
	input  bp_pkg::pc_t wr_target,
	output logic        predict_taken,
	output bp_pkg::pc_t next_pc
);

	import bp_pkg::*;

	// ========================================
	// Cache storage
	// ========================================

	// 64 entries, direct mapped
	logic [63:0]          btc_valid;
	logic [BTC_TAG_W-1:0] btc_tag    [64];
	pc_t                  btc_target [64];

	btc_idx_t             rd_idx;
	btc_idx_t             wr_idx;
	logic [BTC_TAG_W-1:0] rd_tag;
	logic [BTC_TAG_W-1:0] wr_tag;
	logic                 btc_hit;
	logic                 btc_fill;

	// Index from address bits 7:2, tag from the bits above
	assign rd_idx = fetch_pc[7:2];
	assign rd_tag = fetch_pc[8 +: BTC_TAG_W];
	assign wr_idx = wr_pc[7:2];
	assign wr_tag = wr_pc[8 +: BTC_TAG_W];

	// Only taken branches are allocated
	assign btc_fill = wr_valid && wr_taken;

	// ========================================
	// Lookup
	// ========================================

	// Valid bit gates the tag compare
	// so stale tags of empty entries never hit
	assign btc_hit = btc_valid[rd_idx] && (btc_tag[rd_idx] == rd_tag);

	// Redirect needs both the counter and a known target
	assign predict_taken = pred_taken && btc_hit;

	// Fall through to the next sequential word
	assign next_pc = predict_taken ? btc_target[rd_idx] : fetch_pc + 32'd4;

	// ========================================
	// Fill
	// ========================================

	// Valid bits cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			btc_valid <= '0;
		end else if (btc_fill) begin
			btc_valid[wr_idx] <= 1'b1;
		end
	end

	// Tag and target payload
	always_ff @(posedge clk) begin
		if (btc_fill) begin
			btc_tag[wr_idx]    <= wr_tag;
			btc_target[wr_idx] <= wr_target;
		end
	end

	// Filled entries hold a known tag and target
	a_fill_known: assert property (@(posedge clk) disable iff (rst)
		btc_fill |-> !$isunknown({wr_tag, wr_target}));

endmodule

// File: design/branch_predictor.sv
// Branch prediction unit top level

`timescale 1ns/10ps

module branch_predictor #(
	parameter int BTC_TAG_W = 24
) (
	input  logic        clk,
	input  logic        rst,
	// Fetch side
	input  bp_pkg::pc_t fetch_pc,
	output logic        predict_taken,
	output bp_pkg::pc_t next_pc,
	// Execute side
	input  logic        upd_req,
	input  bp_pkg::pc_t upd_pc,
	input  logic        upd_taken,
	input  bp_pkg::pc_t upd_target,
	output logic        upd_ack
);

	import bp_pkg::*;

	// Write strobe and payload to both tables
	logic wr_valid;
	pc_t  wr_pc;
	logic wr_taken;
	pc_t  wr_target;

	// Counter verdict before the cache check
	logic pred_taken;

	// ========================================
	// Execute side handshake
	// ========================================
	resolve_port i_resolve_port (
		.clk        (clk),
		.rst        (rst),
		.upd_req    (upd_req),
		.upd_pc     (upd_pc),
		.upd_taken  (upd_taken),
		.upd_target (upd_target),
		.upd_ack    (upd_ack),
		.wr_valid   (wr_valid),
		.wr_pc      (wr_pc),
		.wr_taken   (wr_taken),
		.wr_target  (wr_target)
	);

	// Direction from history and counters
	branch_history i_branch_history (
		.clk        (clk),
		.rst        (rst),
		.fetch_pc   (fetch_pc),
		.wr_valid   (wr_valid),
		.wr_pc      (wr_pc),
		.wr_taken   (wr_taken),
		.pred_taken (pred_taken)
	);

	// Target lookup and next fetch address
	target_predictor #(
		.BTC_TAG_W (BTC_TAG_W)
	) i_target_predictor (
		.clk           (clk),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.pred_taken    (pred_taken),
		.wr_valid      (wr_valid),
		.wr_pc         (wr_pc),
		.wr_taken      (wr_taken),
		.wr_target     (wr_target),
		.predict_taken (predict_taken),
		.next_pc       (next_pc)
	);

endmodule

// File: tb/clock_gen.sv
// Testbench clock and reset

`timescale 1ns/10ps

module clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst
);

	// Free running clock, starts low
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// Reset seen high by the first RESET_CYCLES rising edges
	// Released 2 ns after an edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

// File: tb/tb_top.sv
// Branch predictor testbench

`timescale 1ns/10ps

module tb_top;

	import bp_pkg::*;

	localparam int    ACK_TIMEOUT   = 50;
	localparam int    RESET_TIMEOUT = 40;
	localparam string DATA_FILE     = "tb/bp_testdata.txt";

	logic clk;
	logic rst;

	// Fetch side
	pc_t  fetch_pc;
	logic predict_taken;
	pc_t  next_pc;

	// Execute side
	logic upd_req;
	pc_t  upd_pc;
	logic upd_taken;
	pc_t  upd_target;
	logic upd_ack;

	// Idle gap generator
	logic [31:0] lfsr_state;

	clock_gen #(
		.PERIOD_NS    (20),
		.RESET_CYCLES (16)
	) i_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	branch_predictor #(
		.BTC_TAG_W (24)
	) i_dut (
		.clk           (clk),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.predict_taken (predict_taken),
		.next_pc       (next_pc),
		.upd_req       (upd_req),
		.upd_pc        (upd_pc),
		.upd_taken     (upd_taken),
		.upd_target    (upd_target),
		.upd_ack       (upd_ack)
	);

	// ========================================
	// Failure and compare tasks
	// ========================================

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first failure");
	endtask

	// Direction and handshake bits
	task automatic check_taken(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			stop_on_failure($sformatf("error %s: got %h, expected %h",
				name, actual, expected));
		end
	endtask

	// Fetch addresses
	task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
		if (actual !== expected) begin
			stop_on_failure($sformatf("error %s: got %h, expected %h",
				name, actual, expected));
		end
	endtask

	// ========================================
	// Timing helpers
	// ========================================

	// Park 2 ns after the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	// 0 to 3 idle cycles, one LFSR step per bit
	task automatic idle_random_gap();
		int gap;
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			gap = gap * 2 + int'(lfsr_state[0]);
		end
		repeat (gap) next_cycle();
	endtask

	// Wait for the first rising edge that sees reset low
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			stop_on_failure("reset was never released");
		end else begin
			#2;
		end
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (upd_ack !== level && cycles < ACK_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (upd_ack !== level) begin
			stop_on_failure($sformatf("upd_ack did not go to %0d within %0d cycles",
				level, ACK_TIMEOUT));
		end
	endtask

	// ========================================
	// Operations
	// ========================================

	// Full four-phase exchange for one resolved branch
	task automatic run_update(input pc_t pc, input logic taken, input pc_t target);
		// No new request while the last ack is still up
		check_taken("upd_ack before upd_req", upd_ack, 1'b0);
		upd_req    = 1'b1;
		upd_pc     = pc;
		upd_taken  = taken;
		upd_target = target;
		wait_ack(1'b1);
		idle_random_gap();
		// Ack holds for as long as the request does
		check_taken("upd_ack while upd_req high", upd_ack, 1'b1);
		upd_req = 1'b0;
		wait_ack(1'b0);
	endtask

	// Prediction is combinational, sampled mid cycle
	task automatic check_prediction(input pc_t pc, input logic exp_taken, input pc_t exp_next);
		fetch_pc = pc;
		#5;
		check_taken($sformatf("predict_taken at fetch_pc %h", pc), predict_taken, exp_taken);
		check_pc($sformatf("next_pc at fetch_pc %h", pc), next_pc, exp_next);
		next_cycle();
	endtask

	function automatic bit is_blank_or_comment(input string line);
		byte c;
		if (line.len() == 0) begin
			return 1'b1;
		end
		c = line.getc(0);
		return (c == "#" || c == " " || c == "\t" || c == "\n" || c == "\r");
	endfunction

	task automatic run_testdata(output int ops);
		int         fd;
		int         n;
		string      line;
		logic [7:0] op;
		pc_t        pc;
		logic       taken;
		pc_t        target;
		logic       exp_taken;
		pc_t        exp_next;
		ops = 0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			stop_on_failure({"cannot open the test data file ", DATA_FILE});
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && !is_blank_or_comment(line)) begin
					n = $sscanf(line, "%c %h %h %h %h %h",
						op, pc, taken, target, exp_taken, exp_next);
					if (n != 6) begin
						stop_on_failure({"malformed test data line: ", line});
					end else if (op == "U") begin
						idle_random_gap();
						run_update(pc, taken, target);
						ops++;
					end else if (op == "P") begin
						idle_random_gap();
						check_prediction(pc, exp_taken, exp_next);
						ops++;
					end else begin
						stop_on_failure({"unknown operation in test data line: ", line});
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int ops;
		fetch_pc   = '0;
		upd_req    = 1'b0;
		upd_pc     = '0;
		upd_taken  = 1'b0;
		upd_target = '0;
		lfsr_state = 32'd69875;
		wait_reset_release();
		run_testdata(ops);
		if (ops == 0) begin
			stop_on_failure("the test data file held no operations");
		end else begin
			$display("%0d operations checked", ops);
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: compile.f
design/bp_pkg.sv
design/resolve_port.sv
design/branch_history.sv
design/target_predictor.sv
design/branch_predictor.sv
tb/clock_gen.sv
tb/tb_top.sv

// File: Makefile
# Verilator simulation of the branch prediction unit

VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := compile.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
VFLAGS    += --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The testbench stops with a nonzero exit status on any failure
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/bp_testdata.txt
# op pc taken target exp_taken exp_next, all hex
# U sends an update and ignores the last two fields, P checks pc and ignores taken and target
# After reset the cache is empty
P 00001040 0 00000000 0 00001044
P 00003080 0 00000000 0 00003084
P fffffffc 0 00000000 0 00000000
P 00000000 0 00000000 0 00000004
# First taken update fills the cache, counter 0 to 1
U 00001040 1 00002000 0 00000000
P 00001040 0 00000000 1 00002000
P 00001044 0 00000000 0 00001048
P 00005040 0 00000000 0 00005044
# Taken updates saturate at 1
U 00001040 1 00002000 0 00000000
U 00001040 1 00002000 0 00000000
U 00001040 1 00002000 0 00000000
U 00001040 1 00002000 0 00000000
P 00001040 0 00000000 1 00002000
# Two not taken updates in one slot, 1 to 0 to 3
U 00001040 0 00000000 0 00000000
P 00001040 0 00000000 1 00002000
U 00001040 0 00000000 0 00000000
P 00001040 0 00000000 1 00002000
# Second branch steers the history back to slot 11
U 00003080 1 00004000 0 00000000
U 00003080 1 00004000 0 00000000
U 00003080 1 00004000 0 00000000
P 00001040 0 00000000 0 00001044
P 00003080 0 00000000 1 00004000
# Same addresses under other history slots
U 00003080 0 00000000 0 00000000
P 00003080 0 00000000 0 00003084
P 00001040 0 00000000 0 00001044
U 00003080 0 00000000 0 00000000
P 00001040 0 00000000 1 00002000
P 00003080 0 00000000 1 00004000
U 00003080 0 00000000 0 00000000
P 00001040 0 00000000 1 00002000
P 00003080 0 00000000 1 00004000
# Not taken saturates at 2, taken climbs back through 3
U 00003080 0 00000000 0 00000000
U 00003080 0 00000000 0 00000000
P 00003080 0 00000000 0 00003084
U 00003080 0 00000000 0 00000000
U 00003080 0 00000000 0 00000000
P 00003080 0 00000000 0 00003084
U 00003080 1 00004000 0 00000000
P 00003080 0 00000000 0 00003084
U 00003080 1 00004000 0 00000000
P 00003080 0 00000000 1 00004000
# Aliased index with a different tag
P 00005040 0 00000000 0 00005044
U 00005040 1 00006000 0 00000000
U 00005040 1 00006000 0 00000000
P 00005040 0 00000000 1 00006000
P 00001040 0 00000000 0 00001044
P 80001040 0 00000000 0 80001044
